/* hw/adc_if_pkg.sv */
// ------------------------------
// adc interface definitions
// sample format, conversion timing and the
// capture state encoding shared by the timer and deserializer
// ------------------------------

package adc_if_pkg;

  // sample width of the sar converter
  localparam int RESOLUTION = 18;
  // data lanes, da carries the upper bit of each pair
  localparam int LANES = 2;

  // ------------------------------
  // conversion timing, in s_axi_aclk cycles
  // ------------------------------
  localparam int SAMPLE_PERIOD = 40;
  // cnv pulse to first gated clock
  localparam int CONV_CYCLES = 20;
  // gated cycles needed to shift out one result
  localparam int GATE_CYCLES = RESOLUTION / LANES;
  // period counter width
  localparam int PERIOD_W = $clog2(SAMPLE_PERIOD);

  // capture sequence, also reused by the deserializer
  typedef enum logic [1:0] {
    IDLE,
    CONVERT,
    SHIFT,
    DONE
  } capture_state_t;

endpackage

/* hw/buf_pkg.sv */
// ------------------------------
// buffer and host port definitions
// circular buffer geometry, host bus width and opcodes
// ------------------------------

package buf_pkg;

  // circular sample buffer
  localparam int BUF_DEPTH = 16;
  localparam int BUF_AW = 4;

  // host data bus
  localparam int DATA_W = 32;

  // status word layout
  // bit 31 is the sticky overflow flag
  // bits 15..0 count samples written since OP_START, wrapping at 2^16
  localparam int CNT_W = 16;

  // host opcodes
  typedef enum logic [1:0] {
    // clear count and overflow, then run
    OP_START       = 2'd0,
    OP_STOP        = 2'd1,
    // buffer entry at host_addr, zero extended
    OP_READ_SAMPLE = 2'd2,
    OP_READ_STATUS = 2'd3
  } host_op_t;

endpackage

/* hw/conv_timer.sv */
// ------------------------------
// conversion timer
// issues one cnv pulse per sample period and opens the
// clock gate window in which the adc shifts out its result
// ------------------------------

`timescale 1ns/1ps

module conv_timer (
  input  logic s_axi_aclk,
  input  logic rst_n,
  input  logic run_en,
  output logic cnv,
  output logic clk_gate
);

  import adc_if_pkg::*;

  capture_state_t state;
  // cycles since the cnv pulse
  logic [PERIOD_W-1:0] cnt;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          cnt <= '0;
          if (run_en) begin
            state <= CONVERT;
          end
        end
        CONVERT: begin
          // adc busy converting, gate opens at cnt == CONV_CYCLES
          cnt <= cnt + 1'b1;
          if (cnt == PERIOD_W'(CONV_CYCLES - 1)) begin
            state <= SHIFT;
          end
        end
        SHIFT: begin
          cnt <= cnt + 1'b1;
          if (cnt == PERIOD_W'(CONV_CYCLES + GATE_CYCLES - 1)) begin
            state <= DONE;
          end
        end
        default: begin
          // rest of the period, a dropped run_en lets it run out first
          if (cnt == PERIOD_W'(SAMPLE_PERIOD - 1)) begin
            cnt   <= '0;
            state <= run_en ? CONVERT : IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // first cycle of each conversion
  assign cnv = (state == CONVERT) && (cnt == '0);
  assign clk_gate = (state == SHIFT);

endmodule

/* hw/lane_deser.sv */
// ------------------------------
// lane deserializer
// shifts one or two serial lanes into a sample while the
// clock gate is open, msb first
// ------------------------------

`timescale 1ns/1ps

module lane_deser (
  input  logic                              s_axi_aclk,
  input  logic                              rst_n,
  input  logic                              clk_gate,
  input  logic                              da,
  input  logic                              db,
  output logic [adc_if_pkg::RESOLUTION-1:0] sample,
  output logic                              sample_valid
);

  import adc_if_pkg::*;

  capture_state_t state;
  logic [RESOLUTION-1:0] shreg;
  // da is the higher bit of each pair
  logic [1:0] lane_pair;

  assign lane_pair = {da, db};

  // ------------------------------
  // shift register
  // ------------------------------
  // payload only, no reset needed
  always_ff @(posedge s_axi_aclk) begin
    if (clk_gate) begin
      // with one lane only da is taken
      shreg <= {shreg[RESOLUTION-LANES-1:0], lane_pair[1 -: LANES]};
    end
  end

  // ------------------------------
  // gate tracking
  // ------------------------------
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (clk_gate) begin
            state <= SHIFT;
          end
        end
        SHIFT: begin
          // gate has closed, the word is complete
          if (!clk_gate) begin
            state <= DONE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // falling edge of the gate, one cycle after the last gated edge
  assign sample_valid = (state == SHIFT) && !clk_gate;
  assign sample = shreg;

endmodule

/* hw/sample_writer.sv */
// ------------------------------
// sample writer
// holds each captured sample and writes it into the circular
// buffer over a four-phase handshake, keeps count and overflow
// ------------------------------

`timescale 1ns/1ps

module sample_writer (
  input  logic                              s_axi_aclk,
  input  logic                              rst_n,
  input  logic [adc_if_pkg::RESOLUTION-1:0] sample,
  input  logic                              sample_valid,
  input  logic                              clr,
  output logic                              wr_req,
  input  logic                              wr_ack,
  output logic [buf_pkg::BUF_AW-1:0]        wr_addr,
  output logic [adc_if_pkg::RESOLUTION-1:0] wr_data,
  output logic [buf_pkg::CNT_W-1:0]         wr_count,
  output logic                              overflow
);

  // a sample is held until its write handshake completes
  logic busy;

  // held sample
  always_ff @(posedge s_axi_aclk) begin
    if (sample_valid && !busy) begin
      wr_data <= sample;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      wr_req   <= 1'b0;
      wr_addr  <= '0;
      wr_count <= '0;
      overflow <= 1'b0;
    end else begin
      if (sample_valid) begin
        if (busy) begin
          // previous write still pending, drop the new one
          overflow <= 1'b1;
        end else begin
          busy   <= 1'b1;
          wr_req <= 1'b1;
        end
      end
      if (busy && wr_req && wr_ack) begin
        wr_req <= 1'b0;
      end
      // handshake closed once ack is back low
      if (busy && !wr_req && !wr_ack) begin
        busy     <= 1'b0;
        wr_addr  <= wr_addr + 1'b1;
        wr_count <= wr_count + 1'b1;
      end
      // restart from entry 0
      if (clr) begin
        wr_addr  <= '0;
        wr_count <= '0;
        overflow <= 1'b0;
      end
    end
  end

endmodule

/* hw/host_port.sv */
// ------------------------------
// host port
// decodes host opcodes, holds the run enable and passes
// sample reads through to the buffer arbiter
// ------------------------------

`timescale 1ns/1ps

module host_port (
  input  logic                              s_axi_aclk,
  input  logic                              rst_n,
  input  logic                              host_req,
  input  buf_pkg::host_op_t                 host_op,
  input  logic [buf_pkg::BUF_AW-1:0]        host_addr,
  input  logic [buf_pkg::DATA_W-1:0]        host_wdata,
  output logic                              host_ack,
  output logic [buf_pkg::DATA_W-1:0]        host_rdata,
  output logic                              run_en,
  output logic                              clr,
  output logic                              rd_req,
  output logic [buf_pkg::BUF_AW-1:0]        rd_addr,
  input  logic                              rd_ack,
  input  logic [adc_if_pkg::RESOLUTION-1:0] rd_data,
  input  logic [buf_pkg::CNT_W-1:0]         wr_count,
  input  logic                              overflow
);

  import buf_pkg::*;
  import adc_if_pkg::*;

  typedef enum logic [2:0] {
    H_IDLE,
    H_RD_REQ,
    H_RD_HOLD,
    H_RD_REL,
    H_ACK
  } host_state_t;

  host_state_t state;

  // host_wdata carries no meaning for the current opcode set

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= H_IDLE;
      host_ack   <= 1'b0;
      host_rdata <= '0;
      run_en     <= 1'b0;
      clr        <= 1'b0;
      rd_req     <= 1'b0;
      rd_addr    <= '0;
    end else begin
      // one cycle clear pulse
      clr <= 1'b0;
      case (state)
        H_IDLE: begin
          if (host_req) begin
            case (host_op)
              OP_START: begin
                clr        <= 1'b1;
                run_en     <= 1'b1;
                host_rdata <= '0;
                host_ack   <= 1'b1;
                state      <= H_ACK;
              end
              OP_STOP: begin
                run_en     <= 1'b0;
                host_rdata <= '0;
                host_ack   <= 1'b1;
                state      <= H_ACK;
              end
              OP_READ_SAMPLE: begin
                // only this one goes through the arbiter
                rd_addr <= host_addr;
                rd_req  <= 1'b1;
                state   <= H_RD_REQ;
              end
              default: begin
                host_rdata <= {overflow, {(DATA_W - CNT_W - 1){1'b0}}, wr_count};
                host_ack   <= 1'b1;
                state      <= H_ACK;
              end
            endcase
          end
        end
        H_RD_REQ: begin
          if (rd_ack) begin
            host_rdata <= {{(DATA_W - RESOLUTION){1'b0}}, rd_data};
            host_ack   <= 1'b1;
            state      <= H_RD_HOLD;
          end
        end
        H_RD_HOLD: begin
          // buffer stays granted while the host holds req
          if (!host_req) begin
            rd_req <= 1'b0;
            state  <= H_RD_REL;
          end
        end
        H_RD_REL: begin
          if (!rd_ack) begin
            host_ack <= 1'b0;
            state    <= H_IDLE;
          end
        end
        default: begin
          if (!host_req) begin
            host_ack <= 1'b0;
            state    <= H_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* hw/shared_buffer.sv */
// ------------------------------
// shared sample buffer
// round-robin arbiter between the sample writer and the
// host read path in front of the circular sample memory
// ------------------------------

`timescale 1ns/1ps

module shared_buffer (
  input  logic                              s_axi_aclk,
  input  logic                              rst_n,
  input  logic                              wr_req,
  input  logic [buf_pkg::BUF_AW-1:0]        wr_addr,
  input  logic [adc_if_pkg::RESOLUTION-1:0] wr_data,
  output logic                              wr_ack,
  input  logic                              rd_req,
  input  logic [buf_pkg::BUF_AW-1:0]        rd_addr,
  output logic                              rd_ack,
  output logic [adc_if_pkg::RESOLUTION-1:0] rd_data
);

  import buf_pkg::*;
  import adc_if_pkg::*;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_WR,
    OWN_RD
  } owner_t;

  logic [RESOLUTION-1:0] mem [BUF_DEPTH];
  owner_t owner;
  // set when the read side won the last grant
  logic last_rd;
  logic do_write;
  logic do_read;

  // access happens in the cycle ack is raised
  assign do_write = (owner == OWN_WR) && !wr_ack;
  assign do_read  = (owner == OWN_RD) && !rd_ack;

  // ------------------------------
  // memory
  // ------------------------------
  always_ff @(posedge s_axi_aclk) begin
    if (do_write) begin
      mem[wr_addr] <= wr_data;
    end
    if (do_read) begin
      rd_data <= mem[rd_addr];
    end
  end

  // ------------------------------
  // arbiter
  // ------------------------------
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      owner   <= OWN_NONE;
      last_rd <= 1'b0;
      wr_ack  <= 1'b0;
      rd_ack  <= 1'b0;
    end else begin
      case (owner)
        OWN_NONE: begin
          // both asking, the side not served last time goes first
          if (wr_req && (!rd_req || last_rd)) begin
            owner   <= OWN_WR;
            last_rd <= 1'b0;
          end else if (rd_req) begin
            owner   <= OWN_RD;
            last_rd <= 1'b1;
          end
        end
        OWN_WR: begin
          if (!wr_ack) begin
            wr_ack <= 1'b1;
          end else if (!wr_req) begin
            wr_ack <= 1'b0;
            owner  <= OWN_NONE;
          end
        end
        default: begin
          if (!rd_ack) begin
            rd_ack <= 1'b1;
          end else if (!rd_req) begin
            rd_ack <= 1'b0;
            owner  <= OWN_NONE;
          end
        end
      endcase
    end
  end

endmodule

/* hw/adc_capture_top.sv */
// ------------------------------
// sar adc capture top level
// conversion timing, lane capture, sample buffer
// and the host req/ack port
// ------------------------------

`timescale 1ns/1ps

module adc_capture_top (
  input  logic                       s_axi_aclk,
  input  logic                       rst_n,
  // adc side
  output logic                       cnv,
  output logic                       clk_gate,
  input  logic                       da,
  input  logic                       db,
  // host side
  input  logic                       host_req,
  input  buf_pkg::host_op_t          host_op,
  input  logic [buf_pkg::BUF_AW-1:0] host_addr,
  input  logic [buf_pkg::DATA_W-1:0] host_wdata,
  output logic                       host_ack,
  output logic [buf_pkg::DATA_W-1:0] host_rdata
);

  import adc_if_pkg::*;
  import buf_pkg::*;

  // ------------------------------
  // internal wires
  // ------------------------------
  logic                  run_en;
  logic                  clr;
  logic [RESOLUTION-1:0] sample;
  logic                  sample_valid;
  // write path
  logic                  wr_req;
  logic                  wr_ack;
  logic [BUF_AW-1:0]     wr_addr;
  logic [RESOLUTION-1:0] wr_data;
  logic [CNT_W-1:0]      wr_count;
  logic                  overflow;
  // read path
  logic                  rd_req;
  logic                  rd_ack;
  logic [BUF_AW-1:0]     rd_addr;
  logic [RESOLUTION-1:0] rd_data;

  conv_timer conv_timer_inst (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .run_en     (run_en),
    .cnv        (cnv),
    .clk_gate   (clk_gate)
  );

  lane_deser lane_deser_inst (
    .s_axi_aclk   (s_axi_aclk),
    .rst_n        (rst_n),
    .clk_gate     (clk_gate),
    .da           (da),
    .db           (db),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  sample_writer sample_writer_inst (
    .s_axi_aclk   (s_axi_aclk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .clr          (clr),
    .wr_req       (wr_req),
    .wr_ack       (wr_ack),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_count     (wr_count),
    .overflow     (overflow)
  );

  host_port host_port_inst (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .host_req   (host_req),
    .host_op    (host_op),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .run_en     (run_en),
    .clr        (clr),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_ack     (rd_ack),
    .rd_data    (rd_data),
    .wr_count   (wr_count),
    .overflow   (overflow)
  );

  shared_buffer shared_buffer_inst (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_ack     (wr_ack),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_ack     (rd_ack),
    .rd_data    (rd_data)
  );

endmodule

/* sim/adc_capture_props.sv */
// ------------------------------
// shared buffer handshake checks
// ack exclusivity and ack/req ordering on both ports
// ------------------------------

`timescale 1ns/1ps

module adc_capture_props (
  input logic s_axi_aclk,
  input logic rst_n,
  input logic wr_req,
  input logic wr_ack,
  input logic rd_req,
  input logic rd_ack
);

  // failed assertions so far, watched by the testbench
  int violations = 0;

  // one access at a time
  a_single_ack: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    !(wr_ack && rd_ack))
    else begin
      violations++;
      $error("wr_ack and rd_ack high together");
    end

  // an ack only rises on a pending request
  a_wr_ack_rise: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    $rose(wr_ack) |-> wr_req)
    else begin
      violations++;
      $error("wr_ack rose without wr_req");
    end

  a_rd_ack_rise: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    $rose(rd_ack) |-> rd_req)
    else begin
      violations++;
      $error("rd_ack rose without rd_req");
    end

endmodule

bind shared_buffer adc_capture_props props_inst (
  .s_axi_aclk (s_axi_aclk),
  .rst_n      (rst_n),
  .wr_req     (wr_req),
  .wr_ack     (wr_ack),
  .rd_req     (rd_req),
  .rd_ack     (rd_ack)
);

/* sim/adc_capture_tb.sv */
// ------------------------------
// adc capture testbench
// adc lane model, host req/ack driver and checks of
// capture, circular wrap, overflow and stop behavior
// ------------------------------

`timescale 1ns/1ps

module adc_capture_tb;

  import adc_if_pkg::*;
  import buf_pkg::*;

  logic              s_axi_aclk = 1'b0;
  logic              rst_n;
  logic              cnv;
  logic              clk_gate;
  logic              da = 1'b0;
  logic              db = 1'b0;
  logic              host_req;
  host_op_t          host_op;
  logic [BUF_AW-1:0] host_addr;
  logic [DATA_W-1:0] host_wdata;
  logic              host_ack;
  logic [DATA_W-1:0] host_rdata;

  // adc model state
  logic [RESOLUTION-1:0] adc_word = '0;
  // every cnv pulse seen since time zero
  int cnv_total = 0;
  // cnv_total at the last OP_START, origin of the sample index
  int run_base = 0;

  adc_capture_top adc_capture_top_inst (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db),
    .host_req   (host_req),
    .host_op    (host_op),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata)
  );

  // 100 ns clock period
  always #50 s_axi_aclk = ~s_axi_aclk;

  // n-th sample produced by the adc after OP_START
  function automatic logic [RESOLUTION-1:0] ref_sample(input int n);
    ref_sample = RESOLUTION'(32'h3a5a5 + n);
  endfunction

  // newest sample index that lands in entry k after total writes
  function automatic int newest_index(input int k, input int total);
    newest_index = k + BUF_DEPTH * ((total - 1 - k) / BUF_DEPTH);
  endfunction

  // ------------------------------
  // adc model
  // ------------------------------
  // lanes change on the falling edge, msb first, da is the upper bit
  always @(negedge s_axi_aclk) begin
    if (cnv) begin
      adc_word  <= ref_sample(cnv_total - run_base);
      cnv_total <= cnv_total + 1;
    end else if (clk_gate) begin
      da       <= adc_word[RESOLUTION-1];
      db       <= adc_word[RESOLUTION-2];
      adc_word <= adc_word << LANES;
    end
  end

  // bound handshake assertions end the run as well
  always @(negedge s_axi_aclk) begin
    if (adc_capture_top_inst.shared_buffer_inst.props_inst.violations != 0) begin
      $display("handshake assertion failed in the shared buffer");
      $display("TEST FAIL");
      $fatal(1, "assertion failure");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one falling edge of a bounded wait
  task automatic tick_with_timeout(inout int cycles, input int limit, input string what);
    @(negedge s_axi_aclk);
    cycles++;
    if (cycles > limit) begin
      $display("timeout waiting for %s", what);
      $display("TEST FAIL");
      $fatal(1, "wait limit reached");
    end
  endtask

  // full four-phase host transaction, hold keeps req high after ack
  task automatic host_access(input host_op_t op, input logic [BUF_AW-1:0] addr,
                             input int hold, output logic [DATA_W-1:0] data);
    int cycles;
    host_op   = op;
    host_addr = addr;
    host_req  = 1'b1;
    cycles    = 0;
    while (!host_ack) begin
      tick_with_timeout(cycles, 4 * SAMPLE_PERIOD, "host_ack to rise");
    end
    data = host_rdata;
    repeat (hold) @(negedge s_axi_aclk);
    host_req = 1'b0;
    cycles   = 0;
    while (host_ack) begin
      tick_with_timeout(cycles, 4 * SAMPLE_PERIOD, "host_ack to fall");
    end
  endtask

  task automatic wait_cnv_pulses(input int n);
    int start;
    int cycles;
    start  = cnv_total;
    cycles = 0;
    while ((cnv_total - start) < n) begin
      tick_with_timeout(cycles, (n + 2) * SAMPLE_PERIOD, "cnv pulses");
    end
  endtask

  // stop, let the period in flight finish, then no more cnv
  task automatic stop_and_check_quiet();
    logic [DATA_W-1:0] data;
    int snap;
    host_access(OP_STOP, '0, 0, data);
    snap = cnv_total;
    repeat (3 * SAMPLE_PERIOD) @(negedge s_axi_aclk);
    if (cnv_total != snap) begin
      $display("cnv pulse issued after acquisition was stopped");
      $display("TEST FAIL");
      $fatal(1, "acquisition did not stop");
    end
  endtask

  task automatic check_status(input int total);
    logic [DATA_W-1:0] data;
    host_access(OP_READ_STATUS, '0, 0, data);
    check_value("host_rdata status", data, 32'(total) & 32'h0000_ffff);
  endtask

  task automatic check_buffer(input int total);
    logic [DATA_W-1:0] data;
    int last;
    last = (total < BUF_DEPTH) ? total : BUF_DEPTH;
    for (int k = 0; k < last; k++) begin
      host_access(OP_READ_SAMPLE, BUF_AW'(k), 0, data);
      check_value($sformatf("host_rdata entry %0d", k), data,
                  32'(ref_sample(newest_index(k, total))));
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    logic [DATA_W-1:0] data;
    int total;
    int gap;
    int k;
    void'($urandom(32'hdcae_3103));
    rst_n      = 1'b0;
    host_req   = 1'b0;
    host_op    = OP_STOP;
    host_addr  = '0;
    host_wdata = '0;
    repeat (3) @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    rst_n = 1'b1;

    // idle after reset, no conversions before OP_START
    check_value("cnv", 32'(cnv), 32'h0);
    check_value("clk_gate", 32'(clk_gate), 32'h0);
    check_value("host_ack", 32'(host_ack), 32'h0);
    repeat (2 * SAMPLE_PERIOD) @(negedge s_axi_aclk);
    check_value("cnv pulse count", 32'(cnv_total), 32'h0);

    // short capture, entries hold samples in order
    run_base = cnv_total;
    host_access(OP_START, '0, 0, data);
    wait_cnv_pulses(6);
    stop_and_check_quiet();
    total = cnv_total - run_base;
    check_status(total);
    check_buffer(total);

    // more than BUF_DEPTH samples, buffer wraps
    run_base = cnv_total;
    host_access(OP_START, '0, 0, data);
    wait_cnv_pulses(20);
    stop_and_check_quiet();
    total = cnv_total - run_base;
    check_status(total);
    check_buffer(total);

    // a held read locks the writer out long enough to drop samples
    run_base = cnv_total;
    host_access(OP_START, '0, 0, data);
    wait_cnv_pulses(2);
    host_access(OP_READ_SAMPLE, '0, 3 * SAMPLE_PERIOD, data);
    check_value("host_rdata entry 0", data, 32'(ref_sample(0)));
    host_access(OP_READ_STATUS, '0, 0, data);
    check_value("status overflow", 32'(data[31]), 32'h1);
    host_access(OP_START, '0, 0, data);
    host_access(OP_READ_STATUS, '0, 0, data);
    check_value("status overflow", 32'(data[31]), 32'h0);
    stop_and_check_quiet();

    // reads at random times after stop
    run_base = cnv_total;
    host_access(OP_START, '0, 0, data);
    wait_cnv_pulses(5);
    stop_and_check_quiet();
    total = cnv_total - run_base;
    check_status(total);
    for (int i = 0; i < 8; i++) begin
      gap = int'($urandom % 32);
      repeat (gap) @(negedge s_axi_aclk);
      k = int'($urandom % 32'(total));
      host_access(OP_READ_SAMPLE, BUF_AW'(k), 0, data);
      check_value($sformatf("host_rdata entry %0d", k), data, 32'(ref_sample(k)));
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

/* compile.f */
hw/adc_if_pkg.sv
hw/buf_pkg.sv
hw/conv_timer.sv
hw/lane_deser.sv
hw/sample_writer.sv
hw/host_port.sv
hw/shared_buffer.sv
hw/adc_capture_top.sv
sim/adc_capture_props.sv
sim/adc_capture_tb.sv

/* Makefile */
# Verilator build and run for the adc capture testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= adc_capture_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a non-zero exit status
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
